// File: build.f
hdl/video_timing_pkg.sv
hdl/pixel_pkg.sv
hdl/frame_lock.sv
hdl/sync_timing_gen.sv
hdl/pixel_align.sv
hdl/hdmi_display.sv
verif/tb_hdmi_display.sv

// File: Makefile
# Verilator simulation of the display timing back end.
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_hdmi_display
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	-./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "RESULT: FAIL (see $(LOG))"; \
		exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_hdmi_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_display;

    import pixel_pkg::*;

    // reduced raster, 16 clocks per line and 8 lines per frame.
    localparam int H_SYNC      = 2;
    localparam int H_BP        = 3;
    localparam int H_ACT       = 8;
    localparam int H_FP        = 3;
    localparam int V_SYNC      = 1;
    localparam int V_BP        = 2;
    localparam int V_ACT       = 4;
    localparam int V_FP        = 1;
    localparam int LINE_CLKS   = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int FRAME_LINES = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;
    localparam int X_START     = H_SYNC + H_BP;
    localparam int Y_START     = V_SYNC + V_BP;
    localparam int DATA_DELAY  = 5;
    localparam int MAX_CYCLES  = 2000;  // about 1100 cycles of tests plus margin.

    logic                 clk;
    logic                 rstn;
    logic                 i_vsync;
    pixel_t               i_data;
    logic                 o_hsync;
    logic                 o_vsync;
    logic                 o_de;
    pixel_t               o_data;
    video_timing_pkg::x_t o_x;
    video_timing_pkg::y_t o_y;

    integer     seed;
    int         errors;
    int         cycles;
    int         raster_pos;     // clocks the raster has run since lock.
    logic       model_locked;
    logic       model_vsync_q;
    video_out_t exp_video;
    pixel_t     sent [$];       // words driven but not yet seen at o_data.

    hdmi_display #(
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP)
    ) dut_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_vsync (i_vsync),
        .i_data  (i_data),
        .o_hsync (o_hsync),
        .o_vsync (o_vsync),
        .o_de    (o_de),
        .o_data  (o_data),
        .o_x     (o_x),
        .o_y     (o_y)
    );

    always #10 clk = ~clk;

    // raster outputs expected k clocks after the generator started.
    function automatic video_out_t expected_video(input int k);
        video_out_t v;
        int         p;
        int         ln;
        logic       h_act;
        logic       v_act;
        p     = k % LINE_CLKS;
        ln    = (k / LINE_CLKS) % FRAME_LINES;
        h_act = (p >= X_START) && (p < X_START + H_ACT);
        v_act = (ln >= Y_START) && (ln < Y_START + V_ACT);
        v       = '0;
        v.hsync = (p < H_SYNC);
        v.vsync = (ln < V_SYNC);
        v.de    = h_act && v_act;
        if (v.de) begin
            v.x = video_timing_pkg::x_t'(p - X_START);
            v.y = video_timing_pkg::y_t'(ln - Y_START);
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    // one clock: update the model at the edge, check 2 ns later, then drive.
    task automatic advance_clock();
        pixel_t want;
        @(posedge clk);
        if (!rstn) begin
            raster_pos    = 0;
            model_locked  = 1'b0;
            model_vsync_q = 1'b0;
            exp_video     = '0;
        end else begin
            if (model_locked) begin
                exp_video  = expected_video(raster_pos);
                raster_pos = raster_pos + 1;
            end else begin
                exp_video = '0;
            end
            if (i_vsync && !model_vsync_q) begin
                model_locked = 1'b1;
            end
            model_vsync_q = i_vsync;
        end
        #2;
        compare_value("o_hsync", 32'(exp_video.hsync), 32'(o_hsync));
        compare_value("o_vsync", 32'(exp_video.vsync), 32'(o_vsync));
        compare_value("o_de", 32'(exp_video.de), 32'(o_de));
        compare_value("o_x", 32'(exp_video.x), 32'(o_x));
        compare_value("o_y", 32'(exp_video.y), 32'(o_y));
        if (sent.size() == DATA_DELAY) begin
            want = sent.pop_front();
            compare_value("o_data", 32'(want), 32'(o_data));
        end
        i_data = pixel_t'($random(seed));
        sent.push_back(i_data);
    endtask

    task automatic wait_frame_start();
        logic prev;
        prev = o_vsync;
        advance_clock();
        while (!(o_vsync && !prev)) begin
            prev = o_vsync;
            advance_clock();
        end
    endtask

    task automatic idle_before_lock();
        i_vsync = 1'b0;
        repeat (50) begin
            advance_clock();
            compare_value("idle {o_hsync,o_vsync,o_de,o_x,o_y}", 32'd0,
                          32'({o_hsync, o_vsync, o_de, o_x, o_y}));
        end
    endtask

    task automatic lock_latency();
        i_vsync = 1'b1;
        advance_clock();  // edge N samples the high level.
        compare_value("o_hsync at edge N", 32'd0, 32'(o_hsync));
        compare_value("o_vsync at edge N", 32'd0, 32'(o_vsync));
        advance_clock();
        compare_value("o_hsync at edge N+1", 32'd1, 32'(o_hsync));
        compare_value("o_vsync at edge N+1", 32'd1, 32'(o_vsync));
    endtask

    task automatic raster_structure();
        int hs_count;
        int vs_count;
        int de_count;
        int de_lines;
        wait_frame_start();
        repeat (2) begin
            vs_count = 0;
            de_count = 0;
            de_lines = 0;
            repeat (FRAME_LINES) begin
                hs_count = 0;
                repeat (LINE_CLKS) begin
                    hs_count += int'(o_hsync);
                    vs_count += int'(o_vsync);
                    de_count += int'(o_de);
                    advance_clock();
                end
                compare_value("hsync clocks per line", H_SYNC, hs_count);
            end
            compare_value("vsync clocks per frame", LINE_CLKS * V_SYNC, vs_count);
            compare_value("de clocks per frame", H_ACT * V_ACT, de_count);
        end
    endtask

    task automatic active_coordinates();
        int   x_run;
        int   y_run;
        logic prev_de;
        wait_frame_start();
        x_run   = 0;
        y_run   = 0;
        prev_de = 1'b0;
        repeat (FRAME_CLKS) begin
            if (o_de) begin
                if (!prev_de) begin
                    x_run = 0;
                end
                compare_value("o_x in active area", x_run, 32'(o_x));
                compare_value("o_y in active area", y_run, 32'(o_y));
                x_run++;
            end else begin
                if (prev_de) begin
                    compare_value("active width", H_ACT, x_run);
                    y_run++;
                end
                compare_value("o_x outside active area", 32'd0, 32'(o_x));
                compare_value("o_y outside active area", 32'd0, 32'(o_y));
            end
            prev_de = o_de;
            advance_clock();
        end
        compare_value("active lines per frame", V_ACT, y_run);
    endtask

    task automatic sticky_lock();
        int   rise_at;
        int   rises;
        logic prev;
        prev    = o_vsync;
        rises   = 0;
        rise_at = 0;
        while (rises < 3) begin
            advance_clock();
            i_vsync = ~i_vsync;  // a fresh source edge every other clock.
            if (o_vsync && !prev) begin
                if (rises > 0) begin
                    compare_value("vsync rise spacing", FRAME_CLKS, cycles - rise_at);
                end
                rise_at = cycles;
                rises++;
            end
            prev = o_vsync;
        end
        i_vsync = 1'b0;
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed          = 32'h76a4;
        errors        = 0;
        raster_pos    = 0;
        model_locked  = 1'b0;
        model_vsync_q = 1'b0;
        exp_video     = '0;
        clk           = 1'b0;
        rstn          = 1'b0;
        i_vsync       = 1'b0;
        i_data        = pixel_t'($random(seed));
        sent.push_back(i_data);
        repeat (3) advance_clock();
        rstn = 1'b1;
        idle_before_lock();
        lock_latency();
        raster_structure();
        active_coordinates();
        sticky_lock();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_hdmi_display

`default_nettype wire

// File: hdl/hdmi_display.sv
`timescale 1ns/1ps
`default_nettype none

module hdmi_display #(
    parameter int H_SYNC = video_timing_pkg::H_SYNC,
    parameter int H_BP   = video_timing_pkg::H_BP,
    parameter int H_ACT  = video_timing_pkg::H_ACT,
    parameter int H_FP   = video_timing_pkg::H_FP,
    parameter int V_SYNC = video_timing_pkg::V_SYNC,
    parameter int V_BP   = video_timing_pkg::V_BP,
    parameter int V_ACT  = video_timing_pkg::V_ACT,
    parameter int V_FP   = video_timing_pkg::V_FP
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_vsync,
    input  pixel_pkg::pixel_t    i_data,
    output logic                 o_hsync,
    output logic                 o_vsync,
    output logic                 o_de,
    output pixel_pkg::pixel_t    o_data,
    output video_timing_pkg::x_t o_x,
    output video_timing_pkg::y_t o_y
);

    import pixel_pkg::*;

    logic       locked;
    video_out_t video;

    frame_lock frame_lock_i (
        .clk      (clk),
        .rstn     (rstn),
        .i_vsync  (i_vsync),
        .o_locked (locked)
    );

    sync_timing_gen #(
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP)
    ) sync_timing_gen_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_run   (locked),  // raster starts the clock after lock.
        .o_video (video)
    );

    pixel_align pixel_align_i (
        .clk    (clk),
        .i_data (i_data),
        .o_data (o_data)
    );

    assign o_hsync = video.hsync;
    assign o_vsync = video.vsync;
    assign o_de    = video.de;
    assign o_x     = video.x;
    assign o_y     = video.y;

endmodule : hdmi_display

`default_nettype wire

// File: hdl/pixel_align.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_align (
    input  logic              clk,
    input  pixel_pkg::pixel_t i_data,
    output pixel_pkg::pixel_t o_data
);

    import pixel_pkg::*;

    pixel_t data_q [PIXEL_DELAY];  // stage 0 takes the input.

    always_ff @(posedge clk) begin
        data_q[0] <= i_data;
        for (int i = 1; i < PIXEL_DELAY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign o_data = data_q[PIXEL_DELAY-1];

    // each attempt starts at a sampled input, so the compared history is always real.
    a_delay: assert property (
        @(posedge clk)
        1'b1 |-> ##PIXEL_DELAY (o_data == $past(i_data, PIXEL_DELAY))
    ) else $error("pixel_align: output does not match delayed input");

endmodule : pixel_align

`default_nettype wire

// File: hdl/sync_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sync_timing_gen #(
    parameter int H_SYNC = video_timing_pkg::H_SYNC,
    parameter int H_BP   = video_timing_pkg::H_BP,
    parameter int H_ACT  = video_timing_pkg::H_ACT,
    parameter int H_FP   = video_timing_pkg::H_FP,
    parameter int V_SYNC = video_timing_pkg::V_SYNC,
    parameter int V_BP   = video_timing_pkg::V_BP,
    parameter int V_ACT  = video_timing_pkg::V_ACT,
    parameter int V_FP   = video_timing_pkg::V_FP
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_run,
    output pixel_pkg::video_out_t o_video
);

    import video_timing_pkg::*;
    import pixel_pkg::*;

    typedef enum logic [1:0] {
        ST_SYNC,
        ST_BACK,
        ST_ACTIVE,
        ST_FRONT
    } phase_e;

    phase_e     h_state;
    phase_e     v_state;
    hcnt_t      h_cnt;
    vcnt_t      v_cnt;
    hcnt_t      h_last;
    vcnt_t      v_last;
    logic       h_end;
    logic       v_end;
    logic       line_end;
    video_out_t video_c;

    function automatic phase_e next_phase(input phase_e cur);
        case (cur)
            ST_SYNC:   return ST_BACK;
            ST_BACK:   return ST_ACTIVE;
            ST_ACTIVE: return ST_FRONT;
            default:   return ST_SYNC;
        endcase
    endfunction

    always_comb begin
        case (h_state)
            ST_SYNC:   h_last = hcnt_t'(H_SYNC - 1);
            ST_BACK:   h_last = hcnt_t'(H_BP - 1);
            ST_ACTIVE: h_last = hcnt_t'(H_ACT - 1);
            default:   h_last = hcnt_t'(H_FP - 1);
        endcase
    end

    always_comb begin
        case (v_state)
            ST_SYNC:   v_last = vcnt_t'(V_SYNC - 1);
            ST_BACK:   v_last = vcnt_t'(V_BP - 1);
            ST_ACTIVE: v_last = vcnt_t'(V_ACT - 1);
            default:   v_last = vcnt_t'(V_FP - 1);
        endcase
    end

    assign h_end    = (h_cnt == h_last);
    assign v_end    = (v_cnt == v_last);
    assign line_end = h_end && (h_state == ST_FRONT);  // the vertical axis steps here.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h_state <= ST_SYNC;
            v_state <= ST_SYNC;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (!i_run) begin
            h_state <= ST_SYNC;  // parked at the top left corner until lock.
            v_state <= ST_SYNC;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            if (h_end) begin
                h_state <= next_phase(h_state);
                h_cnt   <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (line_end) begin
                if (v_end) begin
                    v_state <= next_phase(v_state);
                    v_cnt   <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        video_c.hsync = (h_state == ST_SYNC);
        video_c.vsync = (v_state == ST_SYNC);  // covers every clock of the sync lines.
        video_c.de    = (h_state == ST_ACTIVE) && (v_state == ST_ACTIVE);
        video_c.x     = video_c.de ? x_t'(h_cnt) : '0;
        video_c.y     = video_c.de ? y_t'(v_cnt) : '0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_video <= '0;
        end else if (!i_run) begin
            o_video <= '0;
        end else begin
            o_video <= video_c;
        end
    end

    a_no_de_in_hsync: assert property (
        @(posedge clk) disable iff (!rstn)
        (i_run && h_state == ST_SYNC) |=> !o_video.de
    ) else $error("sync_timing_gen: data enable during horizontal sync");

    a_x_range: assert property (
        @(posedge clk) disable iff (!rstn)
        o_video.x < H_ACT
    ) else $error("sync_timing_gen: x outside the active width");

    a_y_range: assert property (
        @(posedge clk) disable iff (!rstn)
        o_video.y < V_ACT
    ) else $error("sync_timing_gen: y outside the active height");

endmodule : sync_timing_gen

`default_nettype wire

// File: hdl/frame_lock.sv
`timescale 1ns/1ps
`default_nettype none

module frame_lock (
    input  logic clk,
    input  logic rstn,
    input  logic i_vsync,
    output logic o_locked
);

    logic vsync_q;
    logic vsync_rise;

    assign vsync_rise = i_vsync && !vsync_q;  // first sample high after a low one.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_q  <= 1'b0;
            o_locked <= 1'b0;
        end else begin
            vsync_q <= i_vsync;
            if (vsync_rise) begin
                o_locked <= 1'b1;  // later edges find it already set.
            end
        end
    end

    // once the raster has started it must never be stopped by the source.
    a_lock_sticky: assert property (
        @(posedge clk) disable iff (!rstn)
        o_locked |=> o_locked
    ) else $error("frame_lock: lock dropped while out of reset");

endmodule : frame_lock

`default_nettype wire

// File: hdl/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    typedef logic [15:0] pixel_t;  // rgb565 word.

    // clocks from i_data to o_data, matching the source latency.
    localparam int PIXEL_DELAY = 5;

    typedef struct packed {
        logic                 hsync;
        logic                 vsync;
        logic                 de;
        video_timing_pkg::x_t x;
        video_timing_pkg::y_t y;
    } video_out_t;

endpackage : pixel_pkg

`default_nettype wire

// File: hdl/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

    // horizontal widths in clocks for the 1280x720 raster.
    localparam int H_SYNC = 12;
    localparam int H_BP   = 300;
    localparam int H_ACT  = 1280;
    localparam int H_FP   = 300;

    // vertical widths in lines.
    localparam int V_SYNC = 2;
    localparam int V_BP   = 9;
    localparam int V_ACT  = 720;
    localparam int V_FP   = 9;

    localparam int X_BITS   = 11;  // holds 0 to 1279.
    localparam int Y_BITS   = 10;  // holds 0 to 719.
    localparam int CNT_BITS = 12;  // wide enough for the longest interval.

    typedef logic [X_BITS-1:0]   x_t;     // active area column.
    typedef logic [Y_BITS-1:0]   y_t;     // active area row.
    typedef logic [CNT_BITS-1:0] hcnt_t;  // clock position within a horizontal interval.
    typedef logic [CNT_BITS-1:0] vcnt_t;  // line position within a vertical interval.

endpackage : video_timing_pkg

`default_nettype wire
